// File: tb.f
+incdir+sim
hdl/audio_pkg.sv
hdl/frame_timing_if.sv
hdl/frame_timer.sv
hdl/i2s_capture.sv
hdl/stereo_serializer.sv
hdl/bridge_top.sv
sim/tb_clock.sv
sim/tb_top.sv

// File: run.sh
#!/bin/sh
# build tb_top with Verilator, run it and look for the pass line in its output
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f -o tb_sim
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx "sim passed"

// File: sim/tb_tests.svh
/* directed tests for tb_top, run in order
   each test leaves the bridge stopped and the host queue empty */

task automatic start_bridge(input logic dsd);
    use_dsd_i = dsd;
    start_i = 1'b1;
    next_cycles(1);
endtask

task automatic stop_bridge();
    start_i = 1'b0;
    use_dsd_i = 1'b0;
    next_cycles(2);
endtask

task automatic queue_random_pairs(input int n);
    audio_pkg::stereo_t pair;
    sent_q.delete();
    pcm_words.delete();
    pcm_chans.delete();
    dsd1_words.delete();
    dsd2_words.delete();
    for (int i = 0; i < n; i++) begin
        pair.left = $random(seed);
        pair.right = $random(seed);
        host_q.push_back(pair);
        sent_q.push_back(pair);
    end
endtask

task automatic test_idle();
    for (int i = 0; i < 200; i++) begin
        if ({lrck_o, active_o, out_clk_o, out_lrck_dsd1_o, out_data_dsd2_o} !== 5'b0) begin
            report_mismatch("idle", 64'd0,
                            {lrck_o, active_o, out_clk_o, out_lrck_dsd1_o, out_data_dsd2_o});
        end
        next_cycles(1);
    end
endtask

task automatic test_frame_clock();
    logic exp_lrck;
    start_bridge(1'b0);
    for (int i = 0; i < 4 * audio_pkg::FRAME_SLOTS; i++) begin
        // 32 slots low for left, 32 high for right
        exp_lrck = (i % audio_pkg::FRAME_SLOTS) >= 32;
        if (active_o !== 1'b1) begin
            report_mismatch("frame_clock active", 64'd1, active_o);
        end
        if (lrck_o !== exp_lrck) begin
            report_mismatch("frame_clock lrck", exp_lrck, lrck_o);
        end
        next_cycles(1);
    end
    stop_bridge();
endtask

task automatic test_pcm_loopback();
    int idx;
    queue_random_pairs(8);
    start_bridge(1'b0);
    next_cycles(12 * audio_pkg::FRAME_SLOTS);
    stop_bridge();
    idx = 0;
    // idle zeros run until the first captured pair
    while (idx < pcm_words.size() && pcm_words[idx] == '0) begin
        idx++;
    end
    if (pcm_words.size() < idx + 2 * sent_q.size()) begin
        report_problem($sformatf("pcm_loopback decoded only %0d words", pcm_words.size()));
    end else begin
        foreach (sent_q[i]) begin
            if (pcm_words[idx + 2*i] !== sent_q[i].left || pcm_chans[idx + 2*i] !== 1'b0) begin
                report_mismatch("pcm_loopback left", {1'b0, sent_q[i].left},
                                {pcm_chans[idx + 2*i], pcm_words[idx + 2*i]});
            end
            if (pcm_words[idx + 2*i + 1] !== sent_q[i].right
                    || pcm_chans[idx + 2*i + 1] !== 1'b1) begin
                report_mismatch("pcm_loopback right", {1'b1, sent_q[i].right},
                                {pcm_chans[idx + 2*i + 1], pcm_words[idx + 2*i + 1]});
            end
        end
    end
endtask

task automatic test_dsd_lanes();
    logic clk_prev;
    queue_random_pairs(6);
    start_bridge(1'b1);
    clk_prev = out_clk_o;
    for (int k = 1; k <= 9 * audio_pkg::FRAME_SLOTS; k++) begin
        next_cycles(1);
        // the DSD clock needs a few cycles after start before it runs
        if (k >= 8 && out_clk_o === clk_prev) begin
            report_mismatch("dsd_lanes out_clk", !clk_prev, out_clk_o);
        end
        clk_prev = out_clk_o;
    end
    stop_bridge();
    if (dsd1_words.size() < sent_q.size() + 1 || dsd2_words.size() < sent_q.size() + 1) begin
        report_problem($sformatf("dsd_lanes decoded only %0d words", dsd1_words.size()));
    end else begin
        if (dsd1_words[0] !== audio_pkg::DSD_IDLE_WORD) begin
            report_mismatch("dsd_lanes dsd1 idle", audio_pkg::DSD_IDLE_WORD, dsd1_words[0]);
        end
        if (dsd2_words[0] !== audio_pkg::DSD_IDLE_WORD) begin
            report_mismatch("dsd_lanes dsd2 idle", audio_pkg::DSD_IDLE_WORD, dsd2_words[0]);
        end
        foreach (sent_q[i]) begin
            if (dsd1_words[i + 1] !== sent_q[i].left) begin
                report_mismatch("dsd_lanes dsd1", sent_q[i].left, dsd1_words[i + 1]);
            end
            if (dsd2_words[i + 1] !== sent_q[i].right) begin
                report_mismatch("dsd_lanes dsd2", sent_q[i].right, dsd2_words[i + 1]);
            end
        end
    end
endtask

task automatic test_mode_lock_stop();
    logic clk_prev;
    audio_pkg::stereo_t ones;
    // all-ones words keep the PCM data lane high through the output frames
    ones = '1;
    host_q.push_back(ones);
    host_q.push_back(ones);
    start_bridge(1'b0);
    // stop lands in slot 40 while lrck and the data lane are high
    for (int k = 1; k <= 2 * audio_pkg::FRAME_SLOTS + 40; k++) begin
        use_dsd_i = ~use_dsd_i;
        next_cycles(1);
        if (out_clk_o !== 1'b0) begin
            report_mismatch("mode_lock pcm out_clk", 64'd0, out_clk_o);
        end
    end
    start_i = 1'b0;
    next_cycles(2);
    if ({active_o, lrck_o, out_clk_o, out_lrck_dsd1_o, out_data_dsd2_o} !== 5'b0) begin
        report_mismatch("mode_lock stop", 64'd0,
                        {active_o, lrck_o, out_clk_o, out_lrck_dsd1_o, out_data_dsd2_o});
    end
    start_bridge(1'b1);
    clk_prev = out_clk_o;
    for (int k = 1; k <= 2 * audio_pkg::FRAME_SLOTS; k++) begin
        use_dsd_i = ~use_dsd_i;
        next_cycles(1);
        if (lrck_o !== ((k % audio_pkg::FRAME_SLOTS) >= 32)) begin
            report_mismatch("mode_lock restart lrck", (k % audio_pkg::FRAME_SLOTS) >= 32, lrck_o);
        end
        if (k >= 8 && out_clk_o === clk_prev) begin
            report_mismatch("mode_lock dsd out_clk", !clk_prev, out_clk_o);
        end
        clk_prev = out_clk_o;
    end
    stop_bridge();
endtask

// File: sim/tb_top.sv
/* testbench for bridge_top, acts as the I2S host and decodes both output formats
   inputs change and outputs are read 2 ns after each rising bck edge */
`timescale 1ns/1ps

module tb_top;

    // five tests of at most 12 frames each stay far below this
    localparam int TIMEOUT_CYCLES = 20000;

    logic bck;
    logic reset_n;
    logic start_i = 1'b0;
    logic use_dsd_i = 1'b0;
    logic sdata_i = 1'b0;
    logic lrck_o;
    logic active_o;
    logic out_clk_o;
    logic out_lrck_dsd1_o;
    logic out_data_dsd2_o;

    int errors = 0;
    int cycle_count = 0;
    int seed = 12;

    // host side, one 64-bit frame per queue entry
    audio_pkg::stereo_t host_q[$];
    audio_pkg::stereo_t sent_q[$];
    logic [2*audio_pkg::SAMPLE_W-1:0] host_frame = '0;
    int host_slot = 0;
    logic host_running = 1'b0;
    logic host_lr_prev = 1'b0;

    // decoded output words
    audio_pkg::sample_t pcm_words[$];
    logic pcm_chans[$];
    audio_pkg::sample_t dsd1_words[$];
    audio_pkg::sample_t dsd2_words[$];
    audio_pkg::sample_t pcm_sr;
    audio_pkg::sample_t lane1_sr;
    audio_pkg::sample_t lane2_sr;
    int pcm_bits_left = 0;
    logic pcm_chan = 1'b0;
    logic pcm_lr_prev = 1'b0;
    int dsd_bits = 0;
    logic dsd_clk_prev = 1'b0;

    tb_clock u_tb_clock (
        .bck(bck),
        .reset_n(reset_n)
    );

    bridge_top u_bridge_top (
        .bck(bck),
        .reset_n(reset_n),
        .start_i(start_i),
        .use_dsd_i(use_dsd_i),
        .sdata_i(sdata_i),
        .lrck_o(lrck_o),
        .active_o(active_o),
        .out_clk_o(out_clk_o),
        .out_lrck_dsd1_o(out_lrck_dsd1_o),
        .out_data_dsd2_o(out_data_dsd2_o)
    );

    task automatic next_cycles(input int n);
        repeat (n) @(posedge bck);
        #2;
    endtask

    task automatic report_mismatch(input string test, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Error %s: expected %h, actual %h", test, expected, actual);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic drive_host_bit();
        if (!active_o) begin
            host_running = 1'b0;
            host_slot = 0;
            host_lr_prev = 1'b0;
            host_frame = '0;
        end else begin
            // a falling lrck marks slot 0, start is slot 0 too
            if (host_lr_prev && !lrck_o) begin
                host_slot = 0;
            end else if (host_running) begin
                host_slot = (host_slot + 1) % audio_pkg::FRAME_SLOTS;
            end
            host_running = 1'b1;
            host_lr_prev = lrck_o;
            // left MSB in slot 1, right LSB lands in slot 0 of the next frame
            if (host_slot == 1) begin
                if (host_q.size() > 0) begin
                    host_frame = host_q.pop_front();
                end else begin
                    host_frame = '0;
                end
            end else begin
                host_frame = host_frame << 1;
            end
        end
        sdata_i = host_frame[2*audio_pkg::SAMPLE_W-1];
    endtask

    always @(posedge bck) begin
        #2;
        drive_host_bit();
    end

    // PCM decoder, each word starts one bit after an output lrck edge
    always @(posedge bck) begin
        #2;
        if (!active_o) begin
            pcm_bits_left = 0;
            pcm_lr_prev = 1'b0;
        end else begin
            if (pcm_bits_left > 0) begin
                pcm_sr = {pcm_sr[audio_pkg::SAMPLE_W-2:0], out_data_dsd2_o};
                pcm_bits_left--;
                if (pcm_bits_left == 0) begin
                    pcm_words.push_back(pcm_sr);
                    pcm_chans.push_back(pcm_chan);
                end
            end
            if (out_lrck_dsd1_o != pcm_lr_prev) begin
                pcm_bits_left = audio_pkg::SAMPLE_W;
                pcm_chan = out_lrck_dsd1_o;
            end
            pcm_lr_prev = out_lrck_dsd1_o;
        end
    end

    // DSD decoder, both lanes sampled when out_clk_o rises
    always @(posedge bck) begin
        #2;
        if (!active_o) begin
            dsd_bits = 0;
            dsd_clk_prev = 1'b0;
        end else begin
            if (out_clk_o && !dsd_clk_prev) begin
                lane1_sr = {lane1_sr[audio_pkg::SAMPLE_W-2:0], out_lrck_dsd1_o};
                lane2_sr = {lane2_sr[audio_pkg::SAMPLE_W-2:0], out_data_dsd2_o};
                dsd_bits++;
                if (dsd_bits == audio_pkg::SAMPLE_W) begin
                    dsd1_words.push_back(lane1_sr);
                    dsd2_words.push_back(lane2_sr);
                    dsd_bits = 0;
                end
            end
            dsd_clk_prev = out_clk_o;
        end
    end

    always @(posedge bck) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the tests did not finish within %0d cycles", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    `include "tb_tests.svh"

    initial begin
        wait (reset_n === 1'b1);
        next_cycles(1);
        test_idle();
        test_frame_clock();
        test_pcm_loopback();
        test_dsd_lanes();
        test_mode_lock_stop();
        $display("errors: %0d, cycles: %0d", errors, cycle_count);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim/tb_clock.sv
/* free-running bck with a 20 ns period
   reset_n is held low for the first 10 rising edges */
`timescale 1ns/1ps

module tb_clock (
    output logic bck,
    output logic reset_n
);

    initial begin
        bck = 1'b0;
        forever begin
            #10 bck = ~bck;
        end
    end

    // released 2 ns after an edge, like every other input
    initial begin
        reset_n = 1'b0;
        repeat (10) @(posedge bck);
        #2 reset_n = 1'b1;
    end

endmodule

// File: hdl/bridge_top.sv
/* PCM/DSD bridge in master mode, everything on bck
   host must drive sdata_i to lrck_o with the left MSB one slot after lrck falls */
`timescale 1ns/1ps

module bridge_top (
    input  logic bck,
    input  logic reset_n,
    input  logic start_i,
    input  logic use_dsd_i,
    input  logic sdata_i,
    output logic lrck_o,
    output logic active_o,
    output logic out_clk_o,
    output logic out_lrck_dsd1_o,
    output logic out_data_dsd2_o
);

    // captured pair and its one-cycle strobe
    audio_pkg::stereo_t pair;
    logic pair_valid;

    frame_timing_if u_tmg ();

    frame_timer u_frame_timer (
        .bck(bck),
        .reset_n(reset_n),
        .start_i(start_i),
        .use_dsd_i(use_dsd_i),
        .active_o(active_o),
        .lrck_o(lrck_o),
        .tmg(u_tmg.timer)
    );

    i2s_capture u_i2s_capture (
        .bck(bck),
        .reset_n(reset_n),
        .tmg(u_tmg.follower),
        .sdata_i(sdata_i),
        .pair_o(pair),
        .pair_valid_o(pair_valid)
    );

    // no back-pressure, the serializer keeps only the newest pair
    stereo_serializer u_stereo_serializer (
        .bck(bck),
        .reset_n(reset_n),
        .tmg(u_tmg.follower),
        .pair_i(pair),
        .pair_valid_i(pair_valid),
        .out_clk_o(out_clk_o),
        .out_lrck_dsd1_o(out_lrck_dsd1_o),
        .out_data_dsd2_o(out_data_dsd2_o)
    );

endmodule

// File: hdl/stereo_serializer.sv
/* output stage for the latest captured pair, PCM as I2S on bck or DSD on two lanes
   at bck/2; all outputs are registered and fall to 0 one cycle after stop */
`timescale 1ns/1ps

module stereo_serializer (
    input  logic bck,
    input  logic reset_n,
    frame_timing_if.follower tmg,
    input  audio_pkg::stereo_t pair_i,
    input  logic pair_valid_i,
    output logic out_clk_o,
    output logic out_lrck_dsd1_o,
    output logic out_data_dsd2_o
);

    logic is_dsd;
    logic load_now;
    logic have_pair_q;
    logic loaded_q;
    logic lrck_d1_q;
    logic dclk_q;
    logic lane1_q;
    logic lane2_q;
    audio_pkg::sample_t idle_word;
    audio_pkg::stereo_t src_pair;
    audio_pkg::stereo_t latest_q;
    audio_pkg::sample_t left_q;
    audio_pkg::sample_t right_q;

    assign is_dsd = (tmg.mode == audio_pkg::MODE_DSD);
    assign load_now = (tmg.slot == audio_pkg::CAPTURE_SLOT);
    assign idle_word = is_dsd ? audio_pkg::DSD_IDLE_WORD : audio_pkg::PCM_IDLE_WORD;

    // fresh pair first, else the last one, else the idle pattern
    always_comb begin
        if (pair_valid_i) begin
            src_pair = pair_i;
        end else if (have_pair_q) begin
            src_pair = latest_q;
        end else begin
            src_pair = {idle_word, idle_word};
        end
    end

    always_ff @(posedge bck) begin
        if (pair_valid_i) begin
            latest_q <= pair_i;
        end
        if (!tmg.running) begin
            left_q <= '0;
            right_q <= '0;
        end else if (is_dsd) begin
            // lane MSBs go straight to the outputs on the load edge
            if (load_now) begin
                left_q <= {src_pair.left[audio_pkg::SAMPLE_W-2:0], 1'b0};
                right_q <= {src_pair.right[audio_pkg::SAMPLE_W-2:0], 1'b0};
            end else if (tmg.slot[0]) begin
                left_q <= {left_q[audio_pkg::SAMPLE_W-2:0], 1'b0};
                right_q <= {right_q[audio_pkg::SAMPLE_W-2:0], 1'b0};
            end
        end else if (load_now) begin
            left_q <= src_pair.left;
            right_q <= src_pair.right;
        end else begin
            {left_q, right_q} <= {left_q[audio_pkg::SAMPLE_W-2:0], right_q, 1'b0};
        end
    end

    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            {have_pair_q, loaded_q, lrck_d1_q} <= 3'b000;
            {dclk_q, lane1_q, lane2_q} <= 3'b000;
        end else if (!tmg.running) begin
            {have_pair_q, loaded_q, lrck_d1_q} <= 3'b000;
            {dclk_q, lane1_q, lane2_q} <= 3'b000;
        end else begin
            lrck_d1_q <= tmg.frame_lrck;
            if (pair_valid_i) begin
                have_pair_q <= 1'b1;
            end
            if (load_now) begin
                loaded_q <= 1'b1;
            end
            if (is_dsd) begin
                // high in odd slots once the first word is loaded
                dclk_q <= loaded_q && !tmg.slot[0];
                if (load_now) begin
                    lane1_q <= src_pair.left[audio_pkg::SAMPLE_W-1];
                    lane2_q <= src_pair.right[audio_pkg::SAMPLE_W-1];
                end else if (tmg.slot[0]) begin
                    lane1_q <= left_q[audio_pkg::SAMPLE_W-1];
                    lane2_q <= right_q[audio_pkg::SAMPLE_W-1];
                end
            end else begin
                // lrck two cycles behind the master, data one more bit behind it
                dclk_q <= 1'b0;
                lane1_q <= lrck_d1_q;
                lane2_q <= left_q[audio_pkg::SAMPLE_W-1];
            end
        end
    end

    assign out_clk_o = dclk_q;
    assign out_lrck_dsd1_o = lane1_q;
    assign out_data_dsd2_o = lane2_q;

    pcm_no_clk_a : assert property (
        @(posedge bck) disable iff (!reset_n)
        tmg.running && !is_dsd |-> !out_clk_o
    );

    stopped_quiet_a : assert property (
        @(posedge bck) disable iff (!reset_n)
        !tmg.running && !$past(tmg.running) |-> !out_clk_o && !out_lrck_dsd1_o && !out_data_dsd2_o
    );

endmodule

// File: hdl/i2s_capture.sv
/* I2S receiver locked to the master frame, left MSB expected in slot 1
   the frame that is cut short by start is dropped, no partial pair is shown */
`timescale 1ns/1ps

module i2s_capture (
    input  logic bck,
    input  logic reset_n,
    frame_timing_if.follower tmg,
    input  logic sdata_i,
    output audio_pkg::stereo_t pair_o,
    output logic pair_valid_o
);

    // the right LSB arrives in the slot just before the capture slot
    localparam audio_pkg::slot_t done_slot = audio_pkg::slot_t'(audio_pkg::CAPTURE_SLOT - 1);

    logic [2*audio_pkg::SAMPLE_W-2:0] shift_q;
    logic seen_frame_q;
    logic valid_q;
    logic frame_done;

    assign frame_done = tmg.running && (tmg.slot == done_slot);

    // serial data path, one bit per running cycle
    always_ff @(posedge bck) begin
        if (tmg.running) begin
            shift_q <= {shift_q[2*audio_pkg::SAMPLE_W-3:0], sdata_i};
        end
        if (frame_done) begin
            pair_o <= audio_pkg::stereo_t'({shift_q, sdata_i});
        end
    end

    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            seen_frame_q <= 1'b0;
            valid_q <= 1'b0;
        end else if (!tmg.running) begin
            seen_frame_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            // first slot 0 after start closes no complete frame
            valid_q <= frame_done && seen_frame_q;
            if (frame_done) begin
                seen_frame_q <= 1'b1;
            end
        end
    end

    // a stop on the completing edge kills the pending strobe
    assign pair_valid_o = valid_q && tmg.running;

    valid_slot_a : assert property (
        @(posedge bck) disable iff (!reset_n)
        pair_valid_o |-> tmg.slot == audio_pkg::CAPTURE_SLOT
    );

endmodule

// File: hdl/frame_timer.sv
/* master-mode frame timer, start_i must stay high for the whole run
   use_dsd_i is sampled once at start and ignored until the next stop */
`timescale 1ns/1ps

module frame_timer (
    input  logic bck,
    input  logic reset_n,
    input  logic start_i,
    input  logic use_dsd_i,
    output logic active_o,
    output logic lrck_o,
    frame_timing_if.timer tmg
);

    localparam audio_pkg::slot_t last_slot = audio_pkg::slot_t'(audio_pkg::FRAME_SLOTS - 1);

    logic running_q;
    audio_pkg::out_mode_e mode_q;
    audio_pkg::slot_t slot_q;

    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            running_q <= 1'b0;
            mode_q <= audio_pkg::MODE_PCM;
            slot_q <= '0;
        end else if (!running_q) begin
            // counter waits at slot 0 so the first running cycle is slot 0
            slot_q <= '0;
            if (start_i) begin
                running_q <= 1'b1;
                mode_q <= use_dsd_i ? audio_pkg::MODE_DSD : audio_pkg::MODE_PCM;
            end
        end else if (!start_i) begin
            // synchronous stop
            running_q <= 1'b0;
            mode_q <= audio_pkg::MODE_PCM;
            slot_q <= '0;
        end else if (slot_q == last_slot) begin
            slot_q <= '0;
        end else begin
            slot_q <= slot_q + 1'b1;
        end
    end

    // left half is slots 0..31, right half 32..63
    assign lrck_o = slot_q[audio_pkg::SLOT_W-1];
    assign active_o = running_q;

    assign tmg.slot = slot_q;
    assign tmg.running = running_q;
    assign tmg.mode = mode_q;
    assign tmg.frame_lrck = slot_q[audio_pkg::SLOT_W-1];

    // the format must not switch in the middle of a run
    mode_locked_a : assert property (
        @(posedge bck) disable iff (!reset_n)
        running_q && $past(running_q) |-> $stable(mode_q)
    );

    // host word clock is quiet whenever the bridge is stopped
    lrck_idle_a : assert property (
        @(posedge bck) disable iff (!reset_n)
        !running_q |-> !lrck_o && (slot_q == '0)
    );

endmodule

// File: hdl/frame_timing_if.sv
/* frame timing as seen by the datapath, all signals change on bck rising edges
   slot and frame_lrck hold 0 while running is low */
`timescale 1ns/1ps

interface frame_timing_if;

    // position inside the 64-slot frame
    audio_pkg::slot_t slot;

    // high from start until stop
    logic running;

    // locked output format
    audio_pkg::out_mode_e mode;

    // low for the left half, high for the right half
    logic frame_lrck;

    modport timer (
        output slot,
        output running,
        output mode,
        output frame_lrck
    );

    modport follower (
        input slot,
        input running,
        input mode,
        input frame_lrck
    );

endinterface

// File: hdl/audio_pkg.sv
/* frame format is fixed at 32-bit stereo words, 64 bck slots per frame
   DSD mode reuses the same pair as two raw 32-bit lane words */
package audio_pkg;

    // bits per channel word
    localparam int SAMPLE_W = 32;

    // slot counter width and frame length in bck cycles
    localparam int SLOT_W = 6;
    localparam int FRAME_SLOTS = 64;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [SLOT_W-1:0] slot_t;

    // left sits in the upper half, so it leaves the shift register first
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    typedef enum logic {
        MODE_PCM = 1'b0,
        MODE_DSD = 1'b1
    } out_mode_e;

    // sent until the first captured pair arrives
    localparam sample_t DSD_IDLE_WORD = 32'hAAAA_AAAA;
    localparam sample_t PCM_IDLE_WORD = 32'h0000_0000;

    // slot during which a completed pair is presented
    localparam slot_t CAPTURE_SLOT = 6'd1;

endpackage
